/* build.f */
hw/noc_tile_pkg.sv
hw/tile_sync.sv
hw/noc_req_encoder.sv
hw/noc_resp_decoder.sv
hw/noc_tile_top.sv
verification/tb_clock_gen.sv
verification/noc_tile_asserts.sv
verification/noc_tile_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile the NoC tile testbench with Verilator and run it.
# Exits non-zero when the build fails or the run reports a failure.

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module noc_tile_tb -f build.f \
  --Mdir "$OBJ_DIR" -o vnoc_tile_tb
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

# keep running past assertion errors so the testbench can count them
"$OBJ_DIR/vnoc_tile_tb" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q '\*\* FAIL \*\*' "$LOG"; then
  echo "simulation reported failure, see $LOG"
  exit 1
fi

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

echo "simulation finished without failure"
exit 0

/* verification/noc_tile_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the NoC tile front end. Waits out the wake-up reset, then
// runs stores and loads against a small memory node model that stalls
// the request channel. The bound assertions check every transfer.
////////////////////////////////////////////////////////////////////////////
module noc_tile_tb
  import noc_tile_pkg::*;
();

  // 32770 cycles of wake-up plus margin for about 40 transactions
  localparam int unsigned TIMEOUT_CYCLES = 40000;
  localparam int unsigned RESET_CYCLES   = 16;

  logic              clk_i;
  logic              reset_l;
  logic              spc_grst_l_o;
  chipid_t           src_chipid_i;
  coord_t            src_x_i;
  coord_t            src_y_i;
  logic [NR_IRQ-1:0] irq_i;
  logic [NR_IRQ-1:0] irq_o;
  logic              ipi_i, ipi_o, time_irq_i, time_irq_o;
  logic              debug_req_i, debug_req_o;
  logic              wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
  addr_t             wb_adr_i;
  wb_data_t          wb_dat_i;
  wb_sel_t           wb_sel_i;
  wb_data_t          wb_dat_o;
  logic              noc_tx_valid_o, noc_tx_ready_i;
  flit_t             noc_tx_data_o;
  logic              noc_rx_valid_i, noc_rx_ready_o;
  flit_t             noc_rx_data_i;

  integer            seed;
  int unsigned       cycle_cnt = 0;
  int unsigned       tests_run = 0;

  tb_clock_gen u_clock_gen (.clk_o(clk_i));

  noc_tile_top dut (.*);

  function automatic int unsigned assert_failures();
    return dut.u_asserts.fail_cnt;
  endfunction

  // response header addressed back to this tile
  function automatic flit_t resp_header(input msg_type_t msg, input len_t len);
    return {src_chipid_i, src_x_i, src_y_i, len, msg, 8'h00, HOME_FBITS, 6'b0};
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // memory node accepts one request flit after a random stall
  task automatic take_flit();
    int unsigned stall;
    stall = $unsigned($random(seed)) % 4;
    do @(posedge clk_i); while (!noc_tx_valid_o);
    repeat (stall) @(posedge clk_i);
    #1;
    noc_tx_ready_i = 1'b1;
    next_cycle();
    noc_tx_ready_i = 1'b0;
  endtask

  task automatic send_flit(input flit_t data);
    noc_rx_valid_i = 1'b1;
    noc_rx_data_i  = data;
    do @(posedge clk_i); while (!noc_rx_ready_o);
    #1;
    noc_rx_valid_i = 1'b0;
  endtask

  // one Wishbone classic cycle, served by the memory node model
  task automatic wb_access(input logic we);
    logic [31:0] r;
    r        = $random(seed);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_sel_i = r[7:0];
    wb_adr_i = {$random(seed), $random(seed)};
    wb_dat_i = {$random(seed), $random(seed)};
    repeat (we ? 4 : 3) take_flit();
    if (we) begin
      send_flit(resp_header(MSG_STORE_ACK, 8'd0));
    end else begin
      send_flit(resp_header(MSG_LOAD_DATA, 8'd1));
      send_flit({$random(seed), $random(seed)});
    end
    do @(posedge clk_i); while (!wb_ack_o);
    #1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    next_cycle();
  endtask

  task automatic drive_async_lines(input int unsigned cycles);
    logic [31:0] r;
    repeat (cycles) begin
      r           = $random(seed);
      irq_i       = r[NR_IRQ-1:0];
      ipi_i       = r[8];
      time_irq_i  = r[16];
      debug_req_i = r[24];
      next_cycle();
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    $display("test %0d %s done at %0t, assertion failures so far %0d",
             tests_run, name, $time, assert_failures());
  endtask

  initial begin
    logic [31:0] r;
    seed           = 32'h52bf_87c5;
    reset_l        = 1'b0;
    src_chipid_i   = 14'h0123;
    src_x_i        = 8'd3;
    src_y_i        = 8'd5;
    irq_i          = '0;
    ipi_i          = 1'b0;
    time_irq_i     = 1'b0;
    debug_req_i    = 1'b0;
    wb_cyc_i       = 1'b0;
    wb_stb_i       = 1'b0;
    wb_we_i        = 1'b0;
    wb_adr_i       = '0;
    wb_dat_i       = '0;
    wb_sel_i       = '0;
    noc_tx_ready_i = 1'b0;
    noc_rx_valid_i = 1'b0;
    noc_rx_data_i  = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    reset_l = 1'b1;

    // store offered during wake-up, served only once the tile leaves reset
    wb_access(1'b1);
    report_test("reset_release");

    drive_async_lines(64);
    report_test("sync_lines");

    repeat (12) wb_access(1'b1);
    report_test("store_requests");

    repeat (12) wb_access(1'b0);
    report_test("load_round_trips");

    // loads and stores interleaved
    repeat (16) begin
      r = $random(seed);
      wb_access(r[0]);
    end
    report_test("mixed_back_pressure");

    $display("tests run %0d, assertion failures %0d", tests_run, assert_failures());
    if (assert_failures() == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

endmodule

/* verification/noc_tile_asserts.sv */
////////////////////////////////////////////////////////////////////////////
// Concurrent checks on the NoC tile top level, bound into noc_tile_top.
// Expected flits come from the header layout and the Wishbone inputs,
// which the master holds until ack.
////////////////////////////////////////////////////////////////////////////
module noc_tile_asserts
  import noc_tile_pkg::*;
(
  input logic              clk_i,
  input logic              reset_l,
  input logic              spc_grst_l_o,
  input chipid_t           src_chipid_i,
  input coord_t            src_x_i,
  input coord_t            src_y_i,
  input logic [NR_IRQ-1:0] irq_i,
  input logic [NR_IRQ-1:0] irq_o,
  input logic              ipi_i, ipi_o, time_irq_i, time_irq_o,
  input logic              debug_req_i, debug_req_o,
  input logic              wb_cyc_i, wb_stb_i, wb_we_i,
  input addr_t             wb_adr_i,
  input wb_data_t          wb_dat_i,
  input wb_sel_t           wb_sel_i,
  input logic              wb_ack_o,
  input wb_data_t          wb_dat_o,
  input logic              noc_tx_valid_o,
  input flit_t             noc_tx_data_o,
  input logic              noc_tx_ready_i,
  input logic              noc_rx_valid_i,
  input flit_t             noc_rx_data_i,
  input logic              noc_rx_ready_o
);

  int unsigned fail_cnt = 0;
  int unsigned rel_cyc;
  int unsigned req_flits;
  int unsigned rx_cnt;
  logic        tx_fire;
  logic        rx_fire;
  flit_t       exp_hdr;
  flit_t       exp_flit;

  task automatic flag_failure(input string what);
    $error("[ERROR] %0t: %s", $time, what);
    fail_cnt++;
  endtask

  assign tx_fire = noc_tx_valid_o & noc_tx_ready_i;
  assign rx_fire = noc_rx_valid_i & noc_rx_ready_o;

  // home node fields from the top bit down, six zero bits at the bottom
  assign exp_hdr = {HOME_CHIPID, HOME_X, HOME_Y, wb_we_i ? 8'd3 : 8'd2,
                    wb_we_i ? MSG_STORE_REQ : MSG_LOAD_REQ, wb_sel_i, SRC_FBITS, 6'b0};

  always_comb begin
    case (req_flits)
      0:       exp_flit = exp_hdr;
      1:       exp_flit = {34'b0, src_chipid_i, src_x_i, src_y_i};
      2:       exp_flit = wb_adr_i;
      default: exp_flit = wb_dat_i;
    endcase
  end

  // cycles since reset_l rose, flits sent and received per request
  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      rel_cyc   <= 0;
      req_flits <= 0;
      rx_cnt    <= 0;
    end else begin
      rel_cyc <= rel_cyc + 1;
      if (wb_ack_o) begin
        req_flits <= 0;
        rx_cnt    <= 0;
      end else begin
        if (tx_fire) req_flits <= req_flits + 1;
        if (rx_fire) rx_cnt <= rx_cnt + 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // reset and synchronizers
  ////////////////////////////////////////////////////////////////////////////
  a_grst_release: assert property (@(posedge clk_i)
    spc_grst_l_o == (rel_cyc >= 32770))
    else flag_failure("spc_grst_l_o does not match the wake-up count");

  a_quiet_in_reset: assert property (@(posedge clk_i)
    !spc_grst_l_o |-> !wb_ack_o && !noc_tx_valid_o)
    else flag_failure("ack or tx valid while the tile is in reset");

  a_sync_lines: assert property (@(posedge clk_i)
    spc_grst_l_o |-> irq_o == $past(irq_i, 2) && ipi_o == $past(ipi_i, 2) &&
                     time_irq_o == $past(time_irq_i, 2) &&
                     debug_req_o == $past(debug_req_i, 2))
    else flag_failure("synchronized line differs from its input 2 cycles back");

  ////////////////////////////////////////////////////////////////////////////
  // request flits and back-pressure
  ////////////////////////////////////////////////////////////////////////////
  a_tx_flit: assert property (@(posedge clk_i)
    tx_fire |-> noc_tx_data_o == exp_flit)
    else flag_failure("request flit has the wrong value");

  // no valid flit, a new header included, between the last flit and the ack
  a_tx_count: assert property (@(posedge clk_i)
    noc_tx_valid_o |-> req_flits < (wb_we_i ? 4 : 3))
    else flag_failure("request flit sent beyond the end of the request");

  a_tx_hold: assert property (@(posedge clk_i)
    noc_tx_valid_o && !noc_tx_ready_i |=> noc_tx_valid_o && $stable(noc_tx_data_o))
    else flag_failure("request flit dropped or changed under back-pressure");

  ////////////////////////////////////////////////////////////////////////////
  // responses and ack
  ////////////////////////////////////////////////////////////////////////////
  // response channel opens only once the whole request has left
  a_rx_ready: assert property (@(posedge clk_i)
    noc_rx_ready_o |-> req_flits == (wb_we_i ? 4 : 3))
    else flag_failure("response channel ready before the request was sent");

  a_ack_count: assert property (@(posedge clk_i)
    wb_ack_o |-> wb_cyc_i && wb_stb_i && req_flits == (wb_we_i ? 4 : 3) &&
                 rx_cnt == (wb_we_i ? 1 : 2))
    else flag_failure("ack outside a complete request and response");

  a_ack_pulse: assert property (@(posedge clk_i)
    wb_ack_o |=> !wb_ack_o)
    else flag_failure("ack high for more than one cycle");

  a_load_data: assert property (@(posedge clk_i)
    rx_fire && !wb_we_i && rx_cnt == 1 |=> wb_ack_o && wb_dat_o == $past(noc_rx_data_i))
    else flag_failure("load ack late or load data wrong");

  a_store_ack: assert property (@(posedge clk_i)
    rx_fire && wb_we_i |=> wb_ack_o)
    else flag_failure("store ack not one cycle after the response");

endmodule

bind noc_tile_top noc_tile_asserts u_asserts (.*);

/* verification/tb_clock_gen.sv */
////////////////////////////////////////////////////////////////////////////
// Free-running testbench clock, period 8, starting low.
////////////////////////////////////////////////////////////////////////////
module tb_clock_gen (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #4 clk_o = ~clk_o;

endmodule

/* hw/noc_tile_top.sv */
////////////////////////////////////////////////////////////////////////////
// NoC tile front end top level. Reset and input synchronization feed the
// request encoder, which hands each sent request to the response decoder.
// Wishbone classic on the accelerator side, one request in flight.
////////////////////////////////////////////////////////////////////////////
module noc_tile_top
  import noc_tile_pkg::*;
(
  input  logic              clk_i,
  input  logic              reset_l,
  output logic              spc_grst_l_o,
  // tile identity
  input  chipid_t           src_chipid_i,
  input  coord_t            src_x_i,
  input  coord_t            src_y_i,
  // asynchronous lines and their synchronized copies
  input  logic [NR_IRQ-1:0] irq_i,
  input  logic              ipi_i,
  input  logic              time_irq_i,
  input  logic              debug_req_i,
  output logic [NR_IRQ-1:0] irq_o,
  output logic              ipi_o,
  output logic              time_irq_o,
  output logic              debug_req_o,
  // Wishbone classic slave
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  addr_t             wb_adr_i,
  input  wb_data_t          wb_dat_i,
  input  wb_sel_t           wb_sel_i,
  output logic              wb_ack_o,
  output wb_data_t          wb_dat_o,
  // NoC request and response channels
  output logic              noc_tx_valid_o,
  output flit_t             noc_tx_data_o,
  input  logic              noc_tx_ready_i,
  input  logic              noc_rx_valid_i,
  input  flit_t             noc_rx_data_i,
  output logic              noc_rx_ready_o
);

  logic tile_rst_l;
  logic req_sent;
  logic req_is_load;
  logic resp_done;

  assign tile_rst_l = spc_grst_l_o;

  tile_sync u_tile_sync (
    .clk_i        (clk_i),
    .reset_l      (reset_l),
    .irq_i        (irq_i),
    .ipi_i        (ipi_i),
    .time_irq_i   (time_irq_i),
    .debug_req_i  (debug_req_i),
    .spc_grst_l_o (spc_grst_l_o),
    .irq_o        (irq_o),
    .ipi_o        (ipi_o),
    .time_irq_o   (time_irq_o),
    .debug_req_o  (debug_req_o)
  );

  noc_req_encoder u_noc_req_encoder (
    .clk_i          (clk_i),
    .reset_l        (tile_rst_l),
    .src_chipid_i   (src_chipid_i),
    .src_x_i        (src_x_i),
    .src_y_i        (src_y_i),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_we_i        (wb_we_i),
    .wb_adr_i       (wb_adr_i),
    .wb_dat_i       (wb_dat_i),
    .wb_sel_i       (wb_sel_i),
    .resp_done_i    (resp_done),
    .noc_tx_valid_o (noc_tx_valid_o),
    .noc_tx_data_o  (noc_tx_data_o),
    .noc_tx_ready_i (noc_tx_ready_i),
    .req_sent_o     (req_sent),
    .req_is_load_o  (req_is_load)
  );

  noc_resp_decoder u_noc_resp_decoder (
    .clk_i          (clk_i),
    .reset_l        (tile_rst_l),
    .req_sent_i     (req_sent),
    .req_is_load_i  (req_is_load),
    .noc_rx_valid_i (noc_rx_valid_i),
    .noc_rx_data_i  (noc_rx_data_i),
    .noc_rx_ready_o (noc_rx_ready_o),
    .wb_ack_o       (wb_ack_o),
    .wb_dat_o       (wb_dat_o),
    .resp_done_o    (resp_done)
  );

endmodule

/* hw/noc_resp_decoder.sv */
////////////////////////////////////////////////////////////////////////////
// Response side of the NoC bridge. Arms once the request has left, takes
// the response header and, for a load, the data flit, then acks the
// Wishbone cycle and releases the encoder in the same cycle.
////////////////////////////////////////////////////////////////////////////
module noc_resp_decoder
  import noc_tile_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_l,
  input  logic     req_sent_i,
  input  logic     req_is_load_i,
  input  logic     noc_rx_valid_i,
  input  flit_t    noc_rx_data_i,
  output logic     noc_rx_ready_o,
  output logic     wb_ack_o,
  output wb_data_t wb_dat_o,
  output logic     resp_done_o
);

  dec_state_e state_q, state_d;
  logic       armed_q;
  logic       is_load_q;
  logic       ack_q;
  logic       rx_fire;
  logic       done;
  msg_type_t  rx_msg;

  // only accept flits while a request is outstanding
  assign noc_rx_ready_o = armed_q;
  assign rx_fire        = noc_rx_valid_i & armed_q;
  assign rx_msg         = noc_rx_data_i[HDR_MSG_LSB +: $bits(msg_type_t)];

  always_comb begin
    state_d = state_q;
    done    = 1'b0;
    if (rx_fire) begin
      unique case (state_q)
        DEC_IDLE: begin
          if (rx_msg == MSG_LOAD_DATA && is_load_q) begin
            state_d = DEC_DATA;
          end else if (rx_msg == MSG_STORE_ACK || rx_msg == MSG_LOAD_DATA) begin
            done = 1'b1;
          end
          // unknown message types are dropped
        end
        DEC_DATA: begin
          state_d = DEC_IDLE;
          done    = 1'b1;
        end
        default: state_d = DEC_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      state_q   <= DEC_IDLE;
      armed_q   <= 1'b0;
      is_load_q <= 1'b0;
      ack_q     <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_q   <= done;
      if (req_sent_i) begin
        armed_q   <= 1'b1;
        is_load_q <= req_is_load_i;
      end else if (done) begin
        armed_q <= 1'b0;
      end
    end
  end

  // load data word
  always_ff @(posedge clk_i) begin
    if (rx_fire && state_q == DEC_DATA) begin
      wb_dat_o <= wb_data_t'(noc_rx_data_i);
    end
  end

  assign wb_ack_o    = ack_q;
  assign resp_done_o = ack_q;

endmodule

/* hw/noc_req_encoder.sv */
////////////////////////////////////////////////////////////////////////////
// Wishbone classic slave side of the NoC bridge. Captures one request and
// sends it to the home memory node as header, source, address and, for a
// store, data flits. Holds in ENC_WAIT until the response completes.
////////////////////////////////////////////////////////////////////////////
module noc_req_encoder
  import noc_tile_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_l,
  input  chipid_t  src_chipid_i,
  input  coord_t   src_x_i,
  input  coord_t   src_y_i,
  input  logic     wb_cyc_i,
  input  logic     wb_stb_i,
  input  logic     wb_we_i,
  input  addr_t    wb_adr_i,
  input  wb_data_t wb_dat_i,
  input  wb_sel_t  wb_sel_i,
  input  logic     resp_done_i,
  output logic     noc_tx_valid_o,
  output flit_t    noc_tx_data_o,
  input  logic     noc_tx_ready_i,
  output logic     req_sent_o,
  output logic     req_is_load_o
);

  enc_state_e state_q, state_d;
  logic       is_load_q;
  logic       wb_req;
  logic       tx_fire;
  addr_t      adr_q;
  wb_data_t   dat_q;
  wb_sel_t    sel_q;
  len_t       hdr_len;
  msg_type_t  hdr_msg;
  flit_t      hdr_flit;
  flit_t      src_flit;

  assign wb_req  = wb_cyc_i & wb_stb_i & (state_q == ENC_IDLE);
  assign tx_fire = noc_tx_valid_o & noc_tx_ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // flit build
  ////////////////////////////////////////////////////////////////////////////
  assign hdr_len = is_load_q ? LOAD_LEN : STORE_LEN;
  assign hdr_msg = is_load_q ? MSG_LOAD_REQ : MSG_STORE_REQ;

  assign hdr_flit = (flit_t'(HOME_CHIPID) << HDR_CHIP_LSB) |
                    (flit_t'(HOME_X)      << HDR_X_LSB)    |
                    (flit_t'(HOME_Y)      << HDR_Y_LSB)    |
                    (flit_t'(hdr_len)     << HDR_LEN_LSB)  |
                    (flit_t'(hdr_msg)     << HDR_MSG_LSB)  |
                    (flit_t'(sel_q)       << HDR_SEL_LSB)  |
                    (flit_t'(SRC_FBITS)   << HDR_FBITS_LSB);

  // source chip, x and y in the low 30 bits
  assign src_flit = flit_t'({src_chipid_i, src_x_i, src_y_i});

  always_comb begin
    unique case (state_q)
      ENC_HDR:  noc_tx_data_o = hdr_flit;
      ENC_SRC:  noc_tx_data_o = src_flit;
      ENC_ADDR: noc_tx_data_o = flit_t'(adr_q);
      ENC_DATA: noc_tx_data_o = flit_t'(dat_q);
      default:  noc_tx_data_o = '0;
    endcase
  end

  assign noc_tx_valid_o = (state_q == ENC_HDR) || (state_q == ENC_SRC) ||
                          (state_q == ENC_ADDR) || (state_q == ENC_DATA);

  // last flit is the address for a load, the data for a store
  assign req_sent_o    = tx_fire & (((state_q == ENC_ADDR) & is_load_q) |
                                    (state_q == ENC_DATA));
  assign req_is_load_o = is_load_q;

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ENC_IDLE: if (wb_req) state_d = ENC_HDR;
      ENC_HDR:  if (tx_fire) state_d = ENC_SRC;
      ENC_SRC:  if (tx_fire) state_d = ENC_ADDR;
      ENC_ADDR: if (tx_fire) state_d = is_load_q ? ENC_WAIT : ENC_DATA;
      ENC_DATA: if (tx_fire) state_d = ENC_WAIT;
      ENC_WAIT: if (resp_done_i) state_d = ENC_IDLE;
      default:  state_d = ENC_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      state_q   <= ENC_IDLE;
      is_load_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (wb_req) begin
        is_load_q <= ~wb_we_i;
      end
    end
  end

  // request payload, held for the whole transaction
  always_ff @(posedge clk_i) begin
    if (wb_req) begin
      adr_q <= wb_adr_i;
      dat_q <= wb_dat_i;
      sel_q <= wb_sel_i;
    end
  end

endmodule

/* hw/tile_sync.sv */
////////////////////////////////////////////////////////////////////////////
// Tile reset and input synchronization. Holds the tile in reset until the
// wake-up counter saturates, then releases it through a flop chain. The
// interrupt and debug lines pass through chains of the same depth.
////////////////////////////////////////////////////////////////////////////
module tile_sync
  import noc_tile_pkg::*;
(
  input  logic              clk_i,
  input  logic              reset_l,
  input  logic [NR_IRQ-1:0] irq_i,
  input  logic              ipi_i,
  input  logic              time_irq_i,
  input  logic              debug_req_i,
  output logic              spc_grst_l_o,
  output logic [NR_IRQ-1:0] irq_o,
  output logic              ipi_o,
  output logic              time_irq_o,
  output logic              debug_req_o
);

  logic [WAKE_CNT_WIDTH-1:0]          wake_cnt_q;
  logic                               wake_done;
  logic                               rst_gate;
  logic [NR_IRQ+3:0]                  sync_d;
  logic [SYNC_STAGES-1:0][NR_IRQ+3:0] sync_q;

  ////////////////////////////////////////////////////////////////////////////
  // wake-up counter, saturates once the top bit is set
  ////////////////////////////////////////////////////////////////////////////
  assign wake_done = wake_cnt_q[WAKE_CNT_WIDTH-1];

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      wake_cnt_q <= '0;
    end else if (!wake_done) begin
      wake_cnt_q <= wake_cnt_q + 1'b1;
    end
  end

  // gated tile reset
  assign rst_gate = wake_done & reset_l;

  ////////////////////////////////////////////////////////////////////////////
  // all lines share one flop chain, a slice per line
  ////////////////////////////////////////////////////////////////////////////
  assign sync_d = {rst_gate, debug_req_i, time_irq_i, ipi_i, irq_i};

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[SYNC_STAGES-2:0], sync_d};
    end
  end

  assign {spc_grst_l_o, debug_req_o, time_irq_o, ipi_o, irq_o} = sync_q[SYNC_STAGES-1];

endmodule

/* hw/noc_tile_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared definitions for the NoC tile front end: flit and bus widths,
// header field offsets, message codes, home node address and FSM states.
// Every RTL module of the tile imports this package.
////////////////////////////////////////////////////////////////////////////
package noc_tile_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths that carry a meaning
  ////////////////////////////////////////////////////////////////////////////
  typedef logic [63:0] flit_t;
  typedef logic [63:0] addr_t;
  typedef logic [63:0] wb_data_t;
  typedef logic [7:0]  wb_sel_t;
  typedef logic [13:0] chipid_t;
  typedef logic [7:0]  coord_t;
  typedef logic [3:0]  fbits_t;
  typedef logic [7:0]  msg_type_t;
  typedef logic [7:0]  len_t;

  // header flit layout, top bit down, bits [5:0] are zero
  localparam int unsigned HDR_CHIP_LSB  = 50;
  localparam int unsigned HDR_X_LSB     = 42;
  localparam int unsigned HDR_Y_LSB     = 34;
  localparam int unsigned HDR_LEN_LSB   = 26;
  localparam int unsigned HDR_MSG_LSB   = 18;
  localparam int unsigned HDR_SEL_LSB   = 10;
  localparam int unsigned HDR_FBITS_LSB = 6;

  // requests sent by the tile
  localparam msg_type_t MSG_LOAD_REQ  = 8'h31;
  localparam msg_type_t MSG_STORE_REQ = 8'h32;
  // responses from the memory node
  localparam msg_type_t MSG_LOAD_DATA = 8'h33;
  localparam msg_type_t MSG_STORE_ACK = 8'h34;

  // flits after the header
  localparam len_t LOAD_LEN  = 8'd2;
  localparam len_t STORE_LEN = 8'd3;

  // direct-to-memory home node
  localparam chipid_t HOME_CHIPID = 14'h2000;
  localparam coord_t  HOME_X      = 8'd0;
  localparam coord_t  HOME_Y      = 8'd0;
  localparam fbits_t  HOME_FBITS  = 4'h2;
  localparam fbits_t  SRC_FBITS   = 4'h4;

  ////////////////////////////////////////////////////////////////////////////
  // wake-up and synchronizers
  ////////////////////////////////////////////////////////////////////////////
  // top bit sets after 32768 cycles, enough for the network SRAM init
  localparam int unsigned WAKE_CNT_WIDTH = 16;
  localparam int unsigned SYNC_STAGES    = 2;
  localparam int unsigned NR_IRQ         = 2;

  // state machines
  typedef enum logic [2:0] {
    ENC_IDLE, ENC_HDR, ENC_SRC, ENC_ADDR, ENC_DATA, ENC_WAIT
  } enc_state_e;

  typedef enum logic {
    DEC_IDLE, DEC_DATA
  } dec_state_e;

endpackage
